// File: ahb_line_fetch.f
+incdir+hdl
hdl/ahb_pkg.sv
hdl/line_pkg.sv
hdl/cache_biu_ahb.sv
hdl/line_buffer.sv
hdl/line_arbiter.sv
hdl/beat_router.sv
hdl/ahb_line_fetch.sv
bench/clk_gen.sv
bench/ahb_mem_model.sv
bench/tb_ahb_line_fetch.sv

// File: Makefile
# Verilator build for the AHB line fetch front end

VERILATOR  ?= verilator
TOP        := tb_ahb_line_fetch
FILELIST   := ahb_line_fetch.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only if the run printed the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_ahb_line_fetch.sv
/*
 * testbench for the AHB line fetch front end
 * table of line fills and write-backs run through the
 * four-phase client handshake against a wait-state AHB memory
 */
`include "line_fetch_cfg.svh"

module tb_ahb_line_fetch
  import line_pkg::*;
();

  localparam int          P      = `LF_PORTS;
  localparam int          PW     = (P > 1) ? $clog2(P) : 1;
  localparam int          W      = `LF_LINE_WORDS;
  localparam int          BW     = `LF_BEAT_W;
  localparam logic [31:0] FILL_KEY = 32'hA5A5_0000;
  localparam int          CYCLES_PER_TEST = 200;

  // table column values
  localparam bit RD     = 1'b0;
  localparam bit WR     = 1'b1;
  localparam bit SOLO   = 1'b0;
  localparam bit PAIR   = 1'b1;   // PAIR starts with the next entry
  localparam bit DATA   = 1'b0;
  localparam bit INSTR  = 1'b1;
  localparam bit NC     = 1'b0;
  localparam bit CACH   = 1'b1;
  localparam bit OK     = 1'b0;
  localparam bit BUSERR = 1'b1;

  typedef struct packed {
    int          port;
    bit          we;
    bit          pair;
    logic [31:0] addr;
    logic [31:0] seed;        // write word n = seed + n
    logic [1:0]  prv;
    bit          instr;
    bit          cacheable;
    bit          exp_err;
  } test_t;

  logic         HCLK;
  logic         HRESETn;
  logic [31:0]  HADDR;
  logic [31:0]  HWDATA;
  logic [31:0]  HRDATA;
  logic         HWRITE;
  logic         HMASTLOCK;
  logic         HREADY;
  logic         HRESP;
  logic [2:0]   HSIZE;
  logic [2:0]   HBURST;
  logic [3:0]   HPROT;
  logic [1:0]   HTRANS;

  logic [P-1:0] line_req;
  line_req_t    line_cmd [P];
  line_data_t   line_wdata [P];
  logic [P-1:0] line_ack;
  line_data_t   line_rdata [P];
  logic [P-1:0] line_err;

  test_t        tbl [$];
  string        tname [$];
  logic [31:0]  shadow [logic [31:0]];   // words written back so far
  int           cycles = 0;
  int           limit = 0;

  clk_gen #(.PERIOD(10), .RST_CYCLES(2)) u_clk (.HCLK(HCLK), .HRESETn(HRESETn));

  ahb_mem_model u_mem (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HWDATA(HWDATA),
    .HWRITE(HWRITE), .HBURST(HBURST), .HPROT(HPROT), .HTRANS(HTRANS),
    .HRDATA(HRDATA), .HREADY(HREADY), .HRESP(HRESP)
  );

  ahb_line_fetch UUT (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HWDATA(HWDATA),
    .HWRITE(HWRITE), .HSIZE(HSIZE), .HBURST(HBURST), .HPROT(HPROT),
    .HTRANS(HTRANS), .HMASTLOCK(HMASTLOCK), .HRDATA(HRDATA), .HREADY(HREADY),
    .HRESP(HRESP), .line_req(line_req), .line_cmd(line_cmd),
    .line_wdata(line_wdata), .line_ack(line_ack), .line_rdata(line_rdata),
    .line_err(line_err)
  );

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic add_test(input string n, input int port, input bit we, input bit pair,
                          input logic [31:0] addr, input logic [31:0] seed,
                          input logic [1:0] prv, input bit instr, input bit cacheable,
                          input bit exp_err);
    test_t t;
    t = '{port, we, pair, addr, seed, prv, instr, cacheable, exp_err};
    tbl.push_back(t);
    tname.push_back(n);
  endtask

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] expect_word(logic [31:0] a);
    if (shadow.exists(a))
      return shadow[a];
    return a ^ FILL_KEY;                 // memory never written here
  endfunction

  // HPROT bits from the request attributes
  function automatic logic [3:0] expect_prot(test_t t);
    logic [3:0] p;
    p[0] = ~t.instr;                     // data access
    p[1] = (t.prv != PRV_U);             // privileged
    p[2] = t.we;                         // write-backs bufferable
    p[3] = t.cacheable;
    return p;
  endfunction

  task automatic check(input string n, input string what, input logic [31:0] want,
                       input logic [31:0] got);
    assert (got == want)
    else
    begin
      $display("ERROR: %s %s expected %h actual %h", n, what, want, got);
      fail_run();
    end
  endtask

  // one full four-phase exchange on the entry's port
  task automatic run_entry(input int i);
    test_t            t;
    line_req_t        c;
    line_data_t       wl;
    logic [PW-1:0]    pi;
    logic [BW-1:0]    wi;
    logic [31:0]      a;
    int               w;
    t  = tbl[i];
    pi = PW'(t.port);
    c  = '{t.addr, t.we, t.instr, t.cacheable, t.prv};
    for (w = 0; w < W; w++)
    begin
      wi     = BW'(w);
      wl[wi] = t.seed + 32'(w);
    end
    @(posedge HCLK);
    #1;
    line_cmd[pi]   = c;
    line_wdata[pi] = wl;
    line_req[pi]   = 1'b1;
    while (!line_ack[pi])
    begin
      @(posedge HCLK);
      #1;
    end
    check(tname[i], "line_err", 32'(t.exp_err), 32'(line_err[pi]));
    for (w = 0; w < W; w++)
    begin
      wi = BW'(w);
      a  = t.addr + 32'(4 * w);
      if (!t.exp_err && !t.we)
        check(tname[i], $sformatf("word %0d", w), expect_word(a), line_rdata[pi][wi]);
      else if (!t.exp_err)
        shadow[a] = t.seed + 32'(w);     // now in memory
    end
    check(tname[i], "HPROT", 32'(expect_prot(t)), 32'(u_mem.prot_log[t.addr]));
    check(tname[i], "HBURST", 32'h2, 32'(u_mem.burst_log[t.addr]));   // WRAP4
    line_req[pi] = 1'b0;
    while (line_ack[pi])
    begin
      @(posedge HCLK);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  initial
  begin
    int i;
    void'($urandom(75));                 // one seed for the run
    line_req   = '0;
    line_cmd   = '{default: '0};
    line_wdata = '{default: '0};

    // name, port, op, address, write seed, prv, instr, cacheable, expected error
    add_test("fill_p0",   0, RD, SOLO, 32'h0000_1000, 32'h0,         PRV_M, DATA,  CACH, OK);
    add_test("ifetch_p1", 1, RD, SOLO, 32'h0000_2040, 32'h0,         PRV_U, INSTR, CACH, OK);
    add_test("wb_p0",     0, WR, SOLO, 32'h0000_1000, 32'h1234_0000, PRV_S, DATA,  CACH, OK);
    add_test("rd_wb_p0",  0, RD, SOLO, 32'h0000_1000, 32'h0,         PRV_S, DATA,  CACH, OK);
    add_test("pair_rd_a", 0, RD, PAIR, 32'h0000_3000, 32'h0,         PRV_M, DATA,  CACH, OK);
    add_test("pair_rd_b", 1, RD, SOLO, 32'h0000_4010, 32'h0,         PRV_U, INSTR, NC,   OK);
    add_test("pair_wb_a", 0, WR, PAIR, 32'h0000_5000, 32'hCAFE_0000, PRV_M, DATA,  CACH, OK);
    add_test("pair_rd_c", 1, RD, SOLO, 32'h0000_6020, 32'h0,         PRV_S, DATA,  NC,   OK);
    add_test("err_rd_p1", 1, RD, SOLO, 32'hE000_0100, 32'h0,         PRV_M, DATA,  NC,   BUSERR);
    add_test("rd_err_p1", 1, RD, SOLO, 32'h0000_7000, 32'h0,         PRV_M, DATA,  CACH, OK);
    add_test("xport_rd",  1, RD, SOLO, 32'h0000_5000, 32'h0,         PRV_U, DATA,  CACH, OK);
    add_test("err_wb_p0", 0, WR, SOLO, 32'hF000_0000, 32'h5555_0000, PRV_S, DATA,  CACH, BUSERR);
    add_test("rd_err_p0", 0, RD, SOLO, 32'h0000_1000, 32'h0,         PRV_M, DATA,  CACH, OK);
    limit = tbl.size() * CYCLES_PER_TEST;

    @(posedge HRESETn);
    i = 0;
    while (i < tbl.size())
    begin
      if (tbl[i].pair && i + 1 < tbl.size())
      begin
        fork                             // both req rise in one cycle
          run_entry(i);
          run_entry(i + 1);
        join
        i += 2;
      end
      else
      begin
        run_entry(i);
        i += 1;
      end
    end
    $display("PASS: all tests");
    $finish;
  end

  // bus controls outside the table columns, mid-cycle
  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      check("bus_monitor", "HMASTLOCK", 32'h0, 32'(HMASTLOCK));
      if (HTRANS[1])
        check("bus_monitor", "HSIZE", 32'h2, 32'(HSIZE));   // word transfers only
    end
  end

  // run limit
  always @(posedge HCLK)
  begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit)
    begin
      $display("timeout after %0d cycles, a line handshake never finished", cycles);
      fail_run();
    end
  end

endmodule

// File: bench/ahb_mem_model.sv
/*
 * AHB3-Lite slave memory for the testbench
 * random wait states, two-cycle ERROR response from 0xE000_0000 up,
 * untouched words read back as address XOR A5A5_0000;
 * logs HPROT and HBURST of each NONSEQ by its address
 */
`include "line_fetch_cfg.svh"

module ahb_mem_model (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic [`LF_XLEN-1:0] HADDR,
  input  logic [`LF_XLEN-1:0] HWDATA,
  input  logic                HWRITE,
  input  logic [2:0]          HBURST,
  input  logic [3:0]          HPROT,
  input  logic [1:0]          HTRANS,
  output logic [`LF_XLEN-1:0] HRDATA,
  output logic                HREADY,
  output logic                HRESP
);

  localparam logic [31:0] ERR_BASE = 32'hE000_0000;
  localparam logic [31:0] FILL_KEY = 32'hA5A5_0000;
  localparam int          MAX_WAIT = 2;

  logic [31:0] mem [logic [31:0]];        // written words only
  logic [3:0]  prot_log [logic [31:0]];   // last NONSEQ control per address
  logic [2:0]  burst_log [logic [31:0]];

  logic        d_act;     // data phase open
  logic        d_write;
  logic        d_err;     // address in the error window
  logic [31:0] d_addr;
  int          waits;     // wait cycles still to insert

  function automatic logic [31:0] read_word(logic [31:0] a);
    if (mem.exists(a))
      return mem[a];
    return a ^ FILL_KEY;                  // fill pattern
  endfunction

  // next cycle of a data phase: stall, first error cycle or done
  task automatic respond(input int w, input logic err, input logic [31:0] a);
    if (w > 0)
    begin
      HREADY <= 1'b0;
      HRESP  <= 1'b0;
      waits  <= w - 1;
    end
    else if (err)
    begin
      HREADY <= 1'b0;
      HRESP  <= 1'b1;
    end
    else
    begin
      HREADY <= 1'b1;
      HRESP  <= 1'b0;
      HRDATA <= read_word(a);
    end
  endtask

  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      HREADY  <= 1'b1;
      HRESP   <= 1'b0;
      HRDATA  <= '0;
      d_act   <= 1'b0;
      d_write <= 1'b0;
      d_err   <= 1'b0;
      d_addr  <= '0;
      waits   <= 0;
    end
    else if (HREADY)
    begin
      if (d_act && d_write && !HRESP)
        mem[d_addr] = HWDATA;             // write data phase completes
      d_act <= HTRANS[1];                 // NONSEQ or SEQ
      if (HTRANS[1])
      begin
        d_addr  <= HADDR;
        d_write <= HWRITE;
        d_err   <= (HADDR >= ERR_BASE);
        if (HTRANS == 2'b10)
        begin
          prot_log[HADDR]  = HPROT;
          burst_log[HADDR] = HBURST;
        end
        respond(int'($urandom % (MAX_WAIT + 1)), HADDR >= ERR_BASE, HADDR);
      end
      else
      begin
        HREADY <= 1'b1;
        HRESP  <= 1'b0;
      end
    end
    else if (HRESP)
      HREADY <= 1'b1;                     // second error cycle, HRESP stays
    else
      respond(waits, d_err, d_addr);
  end

endmodule

// File: bench/clk_gen.sv
/*
 * testbench clock and reset
 * free-running clock, reset held low for the first cycles
 */
module clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 2
)(
  output logic HCLK,
  output logic HRESETn
);

  initial
  begin
    HCLK    = 1'b0;
    HRESETn = 1'b0;
    repeat (RST_CYCLES) @(posedge HCLK);
    #1 HRESETn = 1'b1;   // released just off the edge
  end

  always #(PERIOD / 2) HCLK = ~HCLK;

endmodule

// File: hdl/ahb_line_fetch.sv
/*
 * AHB line fetch front end, top level
 * per-client line buffers, round-robin arbiter, beat router
 * and one AHB3-Lite master BIU
 */
`include "line_fetch_cfg.svh"

module ahb_line_fetch
  import line_pkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,

  // AHB3-Lite master
  output logic [`LF_XLEN-1:0]  HADDR,
  output logic [`LF_XLEN-1:0]  HWDATA,
  output logic                 HWRITE,
  output logic [2:0]           HSIZE,
  output logic [2:0]           HBURST,
  output logic [3:0]           HPROT,
  output logic [1:0]           HTRANS,
  output logic                 HMASTLOCK,
  input  logic [`LF_XLEN-1:0]  HRDATA,
  input  logic                 HREADY,
  input  logic                 HRESP,

  // cache clients
  input  logic [`LF_PORTS-1:0] line_req,
  input  line_req_t            line_cmd [`LF_PORTS],
  input  line_data_t           line_wdata [`LF_PORTS],
  output logic [`LF_PORTS-1:0] line_ack,
  output line_data_t           line_rdata [`LF_PORTS],
  output logic [`LF_PORTS-1:0] line_err
);

  ////////////////////////////////////////////////////////////
  // interconnect

  logic [`LF_PORTS-1:0]  pend;
  logic [`LF_PORTS-1:0]  grant;
  line_req_t             held_cmd [`LF_PORTS];
  line_data_t            held_wdata [`LF_PORTS];

  logic                  biu_stb;
  logic                  biu_stb_ack;
  line_req_t             biu_cmd;
  logic [`LF_XLEN-1:0]   biu_di;
  logic [`LF_XLEN-1:0]   biu_do;
  logic                  biu_wack;
  logic                  biu_rack;
  logic                  biu_err;

  logic                  beat_vld;
  beat_t                 beat;
  logic [`LF_BEAT_W-1:0] wr_idx;
  logic                  burst_done;

  assign HMASTLOCK = 1'b0;   // no locked transfers

  ////////////////////////////////////////////////////////////
  // blocks

  for (genvar g = 0; g < `LF_PORTS; g++)
  begin : g_buf
    line_buffer u_buf (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .line_req   (line_req[g]),
      .line_cmd   (line_cmd[g]),
      .line_wdata (line_wdata[g]),
      .line_ack   (line_ack[g]),
      .line_rdata (line_rdata[g]),
      .line_err   (line_err[g]),
      .pend       (pend[g]),
      .held_cmd   (held_cmd[g]),
      .held_wdata (held_wdata[g]),
      .grant      (grant[g]),
      .beat_vld   (beat_vld),
      .beat       (beat)
    );
  end

  line_arbiter u_arb (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .pend        (pend),
    .held_cmd    (held_cmd),
    .held_wdata  (held_wdata),
    .grant       (grant),
    .wr_idx      (wr_idx),
    .burst_done  (burst_done),
    .biu_stb     (biu_stb),
    .biu_cmd     (biu_cmd),
    .biu_di      (biu_di),
    .biu_stb_ack (biu_stb_ack)
  );

  beat_router u_router (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .biu_rack   (biu_rack),
    .biu_wack   (biu_wack),
    .biu_err    (biu_err),
    .biu_do     (biu_do),
    .beat_vld   (beat_vld),
    .beat       (beat),
    .wr_idx     (wr_idx),
    .burst_done (burst_done)
  );

  cache_biu_ahb u_biu (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HADDR       (HADDR),
    .HWDATA      (HWDATA),
    .HWRITE      (HWRITE),
    .HSIZE       (HSIZE),
    .HBURST      (HBURST),
    .HPROT       (HPROT),
    .HTRANS      (HTRANS),
    .HRDATA      (HRDATA),
    .HREADY      (HREADY),
    .HRESP       (HRESP),
    .biu_stb     (biu_stb),
    .biu_cmd     (biu_cmd),
    .biu_di      (biu_di),
    .biu_stb_ack (biu_stb_ack),
    .biu_do      (biu_do),
    .biu_wack    (biu_wack),
    .biu_rack    (biu_rack),
    .biu_err     (biu_err)
  );

endmodule

// File: hdl/beat_router.sv
/*
 * beat router
 * counts read and write beats of the running burst, builds
 * the beat record for the owning buffer and flags the end
 */
`include "line_fetch_cfg.svh"

module beat_router
  import line_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  biu_rack,
  input  logic                  biu_wack,
  input  logic                  biu_err,
  input  logic [`LF_XLEN-1:0]   biu_do,
  output logic                  beat_vld,
  output beat_t                 beat,
  output logic [`LF_BEAT_W-1:0] wr_idx,
  output logic                  burst_done
);

  localparam int W = `LF_BEAT_W;
  localparam logic [W-1:0] LAST_IDX = W'(`LF_LINE_WORDS - 1);

  logic [W-1:0] rd_cnt;   // read words delivered
  logic [W-1:0] wr_cnt;   // write data phases done

  assign beat_vld  = biu_rack | biu_wack | biu_err;
  assign beat.data = biu_do;
  assign beat.idx  = biu_rack ? rd_cnt : wr_cnt;
  assign beat.err  = biu_err;
  assign beat.last = biu_err
                   | (biu_rack && rd_cnt == LAST_IDX)
                   | (biu_wack && wr_cnt == LAST_IDX);

  assign burst_done = beat_vld & beat.last;

  // next address phase overlaps this data phase, so look one ahead on wack
  assign wr_idx = wr_cnt + W'(biu_wack);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end
    else if (burst_done)
    begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end
    else if (biu_rack)
      rd_cnt <= rd_cnt + 1'b1;
    else if (biu_wack)
      wr_cnt <= wr_cnt + 1'b1;
  end

endmodule

// File: hdl/line_arbiter.sv
/*
 * line arbiter
 * round-robin pick among pending buffers, strobes the BIU
 * with the winner and muxes its write words; grant is held
 * until the router reports the last beat
 */
`include "line_fetch_cfg.svh"

module line_arbiter
  import line_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic [`LF_PORTS-1:0]  pend,
  input  line_req_t             held_cmd [`LF_PORTS],
  input  line_data_t            held_wdata [`LF_PORTS],
  output logic [`LF_PORTS-1:0]  grant,
  input  logic [`LF_BEAT_W-1:0] wr_idx,
  input  logic                  burst_done,
  output logic                  biu_stb,
  output line_req_t             biu_cmd,
  output logic [`LF_XLEN-1:0]   biu_di,
  input  logic                  biu_stb_ack
);

  localparam int P     = `LF_PORTS;
  localparam int SEL_W = (P > 1) ? $clog2(P) : 1;

  logic [SEL_W-1:0] sel_q;   // current or last owner
  logic [SEL_W-1:0] pick;

  // first pending port after the last owner wins and the owner comes last
  always_comb
  begin
    pick = sel_q;
    for (int k = P; k >= 1; k--)
      if (pend[(int'(sel_q) + k) % P])
        pick = SEL_W'((int'(sel_q) + k) % P);
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      grant   <= '0;
      sel_q   <= '0;
      biu_stb <= 1'b0;
    end
    else if (grant == '0)
    begin
      if (|pend)
      begin
        grant   <= P'(1) << pick;
        sel_q   <= pick;
        biu_stb <= 1'b1;
      end
    end
    else
    begin
      if (biu_stb_ack)
        biu_stb <= 1'b0;
      if (burst_done)
        grant <= '0;                     // buffer drops pend on same edge
    end
  end

  assign biu_cmd = held_cmd[sel_q];
  assign biu_di  = held_wdata[sel_q][wr_idx];   // word the router asks for

  // at most one owner, and only a buffer whose line is still pending
  a_grant_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(grant) && ((grant & ~pend) == '0));

endmodule

// File: hdl/line_buffer.sv
/*
 * per-client line buffer
 * four-phase req/ack endpoint; holds the request and the
 * write-back line until its burst is over, collects fill words
 */
module line_buffer
  import line_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,

  // client
  input  logic       line_req,
  input  line_req_t  line_cmd,
  input  line_data_t line_wdata,
  output logic       line_ack,
  output line_data_t line_rdata,
  output logic       line_err,

  // arbiter
  output logic       pend,
  output line_req_t  held_cmd,
  output line_data_t held_wdata,
  input  logic       grant,

  // beat router
  input  logic       beat_vld,
  input  beat_t      beat
);

  logic capture;   // new request seen
  logic take;      // beat belongs to us

  assign capture = line_req & ~pend & ~line_ack;
  assign take    = grant & beat_vld;

  // handshake state
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      pend     <= 1'b0;
      line_ack <= 1'b0;
      line_err <= 1'b0;
    end
    else if (capture)
    begin
      pend     <= 1'b1;
      line_err <= 1'b0;
    end
    else if (pend && take && beat.last)
    begin
      pend     <= 1'b0;
      line_ack <= 1'b1;
      line_err <= beat.err;
    end
    else if (line_ack && !line_req)
      line_ack <= 1'b0;                    // closing half of four-phase
  end

  // request and line payload
  always_ff @(posedge HCLK)
  begin
    if (capture)
    begin
      held_cmd   <= line_cmd;
      held_wdata <= line_wdata;
    end
    else if (take && !held_cmd.we && !beat.err)
      line_rdata[beat.idx] <= beat.data;   // fill word in place
  end

  // client keeps req up until it sees ack
  a_req_held: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pend |-> line_req);

endmodule

// File: hdl/cache_biu_ahb.sv
/*
 * cache bus interface unit, AHB3-Lite master
 * takes one strobed line request at a time and runs it as a
 * WRAP4 word burst; per-beat read/write acks back to the
 * cache side, error response aborts the burst
 */
`include "line_fetch_cfg.svh"

module cache_biu_ahb
  import ahb_pkg::*;
  import line_pkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,

  // AHB3-Lite master
  output logic [`LF_XLEN-1:0] HADDR,
  output logic [`LF_XLEN-1:0] HWDATA,
  output logic                HWRITE,
  output logic [2:0]          HSIZE,
  output logic [2:0]          HBURST,
  output logic [3:0]          HPROT,
  output logic [1:0]          HTRANS,
  input  logic [`LF_XLEN-1:0] HRDATA,
  input  logic                HREADY,
  input  logic                HRESP,

  // cache side
  input  logic                biu_stb,
  input  line_req_t           biu_cmd,
  input  logic [`LF_XLEN-1:0] biu_di,
  output logic                biu_stb_ack,
  output logic [`LF_XLEN-1:0] biu_do,
  output logic                biu_wack,     // one per write data phase
  output logic                biu_rack,     // one per read data phase
  output logic                biu_err
);

  localparam int W = `LF_BEAT_W;
  localparam logic [W-1:0] SEQ_BEATS = W'(`LF_LINE_WORDS - 1);

  ahb_cmd_t     cmd_q;       // current address phase
  logic [W-1:0] burst_cnt;   // SEQ beats still to issue
  logic         a_act;       // address phase on the bus
  logic         d_act;       // data phase of ours in progress
  logic         d_write;

  // HPROT from the request attributes
  function automatic logic [3:0] prot_of(line_req_t r);
    logic [3:0] p;
    p = (r.prv == PRV_U) ? HPROT_USER : HPROT_PRIVILEGED;
    p |= r.instr ? HPROT_OPCODE : HPROT_DATA;
    p |= r.cacheable ? HPROT_CACHEABLE : HPROT_NON_CACHEABLE;
    p |= r.we ? HPROT_BUFFERABLE : HPROT_NON_BUFFERABLE;  // write-backs may be posted
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // address phase

  assign a_act = (cmd_q.htrans == HTRANS_NONSEQ) || (cmd_q.htrans == HTRANS_SEQ);

  // free once the last address of a burst goes out
  assign biu_stb_ack = HREADY & (burst_cnt == '0) & biu_stb;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      cmd_q     <= '0;                      // IDLE, no transfer
      burst_cnt <= '0;
    end
    else if (HREADY)
    begin
      if (burst_cnt == '0)
      begin
        if (biu_stb)
        begin
          cmd_q.haddr  <= biu_cmd.addr;     // line aligned, first word
          cmd_q.hwrite <= biu_cmd.we;
          cmd_q.hsize  <= HSIZE_WORD;
          cmd_q.hburst <= HBURST_WRAP4;
          cmd_q.hprot  <= prot_of(biu_cmd);
          cmd_q.htrans <= HTRANS_NONSEQ;
          burst_cnt    <= SEQ_BEATS;
        end
        else
          cmd_q.htrans <= HTRANS_IDLE;
      end
      else
      begin
        cmd_q.htrans     <= HTRANS_SEQ;
        cmd_q.haddr[3:0] <= cmd_q.haddr[3:0] + 4'h4;  // 16 byte wrap
        burst_cnt        <= burst_cnt - 1'b1;
      end
    end
    else if (d_act && HRESP == HRESP_ERROR)
    begin
      // first error cycle, cancel what is left
      cmd_q.htrans <= HTRANS_IDLE;
      burst_cnt    <= '0;
    end
  end

  assign HADDR  = cmd_q.haddr;
  assign HWRITE = cmd_q.hwrite;
  assign HSIZE  = cmd_q.hsize;
  assign HBURST = cmd_q.hburst;
  assign HPROT  = cmd_q.hprot;
  assign HTRANS = cmd_q.htrans;

  ////////////////////////////////////////////////////////////
  // data phase

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      d_act   <= 1'b0;
      d_write <= 1'b0;
    end
    else if (HREADY)
    begin
      d_act   <= a_act;
      d_write <= cmd_q.hwrite;
    end
  end

  // write word follows its address phase by one beat
  always_ff @(posedge HCLK)
  begin
    if (HREADY && a_act && cmd_q.hwrite)
      HWDATA <= biu_di;
  end

  assign biu_do   = HRDATA;
  assign biu_rack = HREADY & (HRESP == HRESP_OKAY) & d_act & ~d_write;
  assign biu_wack = HREADY & (HRESP == HRESP_OKAY) & d_act &  d_write;
  assign biu_err  = HREADY & (HRESP == HRESP_ERROR) & d_act;  // second error cycle

  // a burst always opens with NONSEQ
  a_no_seq_after_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (cmd_q.htrans == HTRANS_IDLE) |=> (cmd_q.htrans != HTRANS_SEQ));

endmodule

// File: hdl/line_pkg.sv
/*
 * cache-side line types
 * client request word, per-beat record from the router
 * and the four-word line itself
 */
`include "line_fetch_cfg.svh"

package line_pkg;

  // RISC-V privilege levels as carried in prv
  localparam logic [1:0] PRV_U = 2'b00;
  localparam logic [1:0] PRV_S = 2'b01;
  localparam logic [1:0] PRV_M = 2'b11;

  typedef struct packed {
    logic [`LF_XLEN-1:0] addr;       // line aligned
    logic                we;         // 1 = write-back, 0 = fill
    logic                instr;      // instruction side
    logic                cacheable;
    logic [1:0]          prv;
  } line_req_t;

  typedef struct packed {
    logic [`LF_XLEN-1:0]   data;     // read word, don't care on writes
    logic [`LF_BEAT_W-1:0] idx;      // word within the line
    logic                  last;     // burst over
    logic                  err;      // bus error ended it
  } beat_t;

  typedef logic [`LF_LINE_WORDS-1:0][`LF_XLEN-1:0] line_data_t;

endpackage

// File: hdl/ahb_pkg.sv
/*
 * AHB3-Lite master encodings
 * transfer, burst and size codes, HPROT bits and the
 * address-phase command word held by the bus interface
 */
`include "line_fetch_cfg.svh"

package ahb_pkg;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,
    HBURST_WRAP4  = 3'b010,
    HBURST_WRAP8  = 3'b100,
    HBURST_WRAP16 = 3'b110
  } hburst_t;

  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  // HPROT bits, OR together one of each pair
  localparam logic [3:0] HPROT_OPCODE         = 4'b0000;
  localparam logic [3:0] HPROT_DATA           = 4'b0001;
  localparam logic [3:0] HPROT_USER           = 4'b0000;
  localparam logic [3:0] HPROT_PRIVILEGED     = 4'b0010;
  localparam logic [3:0] HPROT_NON_BUFFERABLE = 4'b0000;
  localparam logic [3:0] HPROT_BUFFERABLE     = 4'b0100;
  localparam logic [3:0] HPROT_NON_CACHEABLE  = 4'b0000;
  localparam logic [3:0] HPROT_CACHEABLE      = 4'b1000;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // everything driven in one address phase
  typedef struct packed {
    logic [`LF_XLEN-1:0] haddr;
    logic                hwrite;
    hsize_t              hsize;
    hburst_t             hburst;
    logic [3:0]          hprot;
    htrans_t             htrans;
  } ahb_cmd_t;

endpackage

// File: hdl/line_fetch_cfg.svh
/*
 * line fetch configuration
 * build-time sizes shared by the packages and the RTL
 */
`ifndef LINE_FETCH_CFG_SVH
`define LINE_FETCH_CFG_SVH

`define LF_XLEN       32  // data and address width, 32 only
`define LF_PORTS      2   // cache clients, 1 to 4

// one line is one WRAP4 burst of words
`define LF_LINE_WORDS 4
`define LF_BEAT_W     2   // beat index width

`endif
